//--- source/cpu_types_pkg.sv
package cpu_types_pkg;

	// two bits are enough to tell back to back retires apart
	localparam int tag_width = 2;

	localparam logic [6:0] opcode_op     = 7'b0110011;	// register-register ALU group
	localparam logic [6:0] opcode_op_imm = 7'b0010011;	// register-immediate ALU group

	typedef struct packed {
		logic [6:0] funct7;
		logic [4:0] rs2;
		logic [4:0] rs1;
		logic [2:0] funct3;
		logic [4:0] rd;
		logic [6:0] opcode;
	} r_type_t;

	typedef struct packed {
		logic [11:0] imm;
		logic [4:0]  rs1;
		logic [2:0]  funct3;
		logic [4:0]  rd;
		logic [6:0]  opcode;
	} i_type_t;

	// decode picks the R-type or I-type view of the same word from the opcode
	typedef union packed {
		r_type_t r;
		i_type_t i;
	} instruction_t;

	typedef enum logic [3:0] {
		alu_add,
		alu_sub,
		alu_and,
		alu_or,
		alu_xor,
		alu_sll,
		alu_srl,
		alu_slt
	} alu_op_t;

	typedef struct packed {
		logic        valid;
		logic [4:0]  inst_rs1;
		logic [4:0]  inst_rs2;
		logic [4:0]  inst_rd;
		alu_op_t     alu_op;
		logic        use_imm;
		logic [31:0] imm;	// already sign-extended
	} fetch_data_t;

	// the register file writes whenever tag moves away from its own copy
	typedef struct packed {
		logic [tag_width-1:0] tag;
		logic [4:0]           inst_rd;
		logic [31:0]          rd;
	} memory_data_t;

endpackage

//--- source/cpu_decode.sv
`timescale 1ns/1ps

module cpu_decode (
	input i_clock,
	input i_reset,

	input                              i_valid,
	input  cpu_types_pkg::instruction_t i_instruction,
	output cpu_types_pkg::fetch_data_t  o_fetch_data
);
	cpu_types_pkg::fetch_data_t decoded;
	cpu_types_pkg::fetch_data_t fetch_data;
	logic known;

	always_comb begin
		decoded = '0;
		decoded.alu_op = cpu_types_pkg::alu_add;
		known = 1'b0;

		case (i_instruction.r.opcode)
			cpu_types_pkg::opcode_op: begin
				decoded.inst_rs1 = i_instruction.r.rs1;
				decoded.inst_rs2 = i_instruction.r.rs2;
				decoded.inst_rd = i_instruction.r.rd;
				known = 1'b1;
				case ({i_instruction.r.funct7, i_instruction.r.funct3})
					{7'h00, 3'b000}: decoded.alu_op = cpu_types_pkg::alu_add;
					{7'h20, 3'b000}: decoded.alu_op = cpu_types_pkg::alu_sub;
					{7'h00, 3'b111}: decoded.alu_op = cpu_types_pkg::alu_and;
					{7'h00, 3'b110}: decoded.alu_op = cpu_types_pkg::alu_or;
					{7'h00, 3'b100}: decoded.alu_op = cpu_types_pkg::alu_xor;
					{7'h00, 3'b001}: decoded.alu_op = cpu_types_pkg::alu_sll;
					{7'h00, 3'b101}: decoded.alu_op = cpu_types_pkg::alu_srl;
					{7'h00, 3'b010}: decoded.alu_op = cpu_types_pkg::alu_slt;
					default:         known = 1'b0;
				endcase
			end
			cpu_types_pkg::opcode_op_imm: begin
				decoded.inst_rs1 = i_instruction.i.rs1;
				decoded.inst_rd = i_instruction.i.rd;	// rs2 stays zero
				decoded.use_imm = 1'b1;
				decoded.imm = {{20{i_instruction.i.imm[11]}}, i_instruction.i.imm};
				known = 1'b1;
				case (i_instruction.i.funct3)
					3'b000:  decoded.alu_op = cpu_types_pkg::alu_add;
					3'b111:  decoded.alu_op = cpu_types_pkg::alu_and;
					3'b110:  decoded.alu_op = cpu_types_pkg::alu_or;
					3'b100:  decoded.alu_op = cpu_types_pkg::alu_xor;
					default: known = 1'b0;
				endcase
			end
			default: known = 1'b0;	// anything else is dropped here
		endcase

		decoded.valid = i_valid && known;
	end

	always_ff @(posedge i_clock) begin
		fetch_data <= decoded;
		if (i_reset)
			fetch_data.valid <= 1'b0;
	end

	assign o_fetch_data = fetch_data;

	// a decoded instruction always comes from a strobe one cycle before
	assert property (@(posedge i_clock) disable iff (i_reset)
		fetch_data.valid |-> $past(i_valid));

endmodule

//--- source/cpu_registers.sv
`timescale 1ns/1ps

module cpu_registers #(
	parameter logic [31:0] stack_pointer = 32'h0000_0000
)(
	input i_clock,
	input i_reset,

	input  cpu_types_pkg::fetch_data_t  i_fetch_data,
	input  cpu_types_pkg::memory_data_t i_memory_data,
	output [31:0]                       o_rs1,
	output [31:0]                       o_rs2
);
	logic [31:0] regs [32];
	logic [31:0] rs1;
	logic [31:0] rs2;
	logic [cpu_types_pkg::tag_width-1:0] write_tag;

	always_ff @(posedge i_clock) begin
		if (i_reset) begin
			rs1 <= 32'h0;
			rs2 <= 32'h0;
			write_tag <= '0;

			for (int i = 0; i < 32; i++)
				regs[i] <= (i == 2) ? stack_pointer : 32'h0;	// x2 starts as the stack pointer
		end
		else begin
			// read first, so a write in this cycle shows up one cycle later
			rs1 <= (i_fetch_data.inst_rs1 != 5'd0) ? regs[i_fetch_data.inst_rs1] : 32'h0;
			rs2 <= (i_fetch_data.inst_rs2 != 5'd0) ? regs[i_fetch_data.inst_rs2] : 32'h0;

			// then write, once per tag step from execute
			if (i_memory_data.tag != write_tag) begin
				if (|i_memory_data.inst_rd)
					regs[i_memory_data.inst_rd] <= i_memory_data.rd;	// x0 is never written
				write_tag <= i_memory_data.tag;
			end
		end
	end

	assign o_rs1 = rs1;
	assign o_rs2 = rs2;

	// x0 keeps its zero whatever execute sends back
	assert property (@(posedge i_clock) disable iff (i_reset)
		regs[0] == 32'h0);

endmodule

//--- source/cpu_execute.sv
`timescale 1ns/1ps

module cpu_execute (
	input i_clock,
	input i_reset,

	input  cpu_types_pkg::fetch_data_t  i_fetch_data,
	input  [31:0]                       i_rs1,
	input  [31:0]                       i_rs2,
	output cpu_types_pkg::memory_data_t o_memory_data,

	output        o_retire,
	output [4:0]  o_retire_rd,
	output [31:0] o_result
);
	cpu_types_pkg::fetch_data_t stage;	// lines up with the registered operands
	logic [31:0] operand_b;
	logic [31:0] alu_result;

	logic [cpu_types_pkg::tag_width-1:0] tag;
	logic        retire;
	logic [4:0]  result_rd;
	logic [31:0] result;

	always_ff @(posedge i_clock) begin
		stage <= i_fetch_data;
		if (i_reset)
			stage.valid <= 1'b0;
	end

	assign operand_b = stage.use_imm ? stage.imm : i_rs2;

	always_comb begin
		case (stage.alu_op)
			cpu_types_pkg::alu_add: alu_result = i_rs1 + operand_b;
			cpu_types_pkg::alu_sub: alu_result = i_rs1 - operand_b;
			cpu_types_pkg::alu_and: alu_result = i_rs1 & operand_b;
			cpu_types_pkg::alu_or:  alu_result = i_rs1 | operand_b;
			cpu_types_pkg::alu_xor: alu_result = i_rs1 ^ operand_b;
			cpu_types_pkg::alu_sll: alu_result = i_rs1 << operand_b[4:0];	// upper bits of the amount ignored
			cpu_types_pkg::alu_srl: alu_result = i_rs1 >> operand_b[4:0];
			cpu_types_pkg::alu_slt: alu_result = {31'h0, $signed(i_rs1) < $signed(operand_b)};
			default:                alu_result = 32'h0;
		endcase
	end

	always_ff @(posedge i_clock) begin
		if (i_reset) begin
			tag <= '0;
			retire <= 1'b0;
		end
		else begin
			retire <= stage.valid;
			if (stage.valid)
				tag <= tag + 1'b1;	// one step per retired instruction
		end
	end

	always_ff @(posedge i_clock) begin
		if (stage.valid) begin
			result <= alu_result;
			result_rd <= stage.inst_rd;
		end
	end

	assign o_memory_data = '{tag: tag, inst_rd: result_rd, rd: result};
	assign o_retire = retire;
	assign o_retire_rd = result_rd;
	assign o_result = result;

	// the tag stands still in every cycle without a retire pulse
	assert property (@(posedge i_clock) disable iff (i_reset)
		!retire |-> tag == $past(tag));

	// the register file relies on the tag moving with every retire
	assert property (@(posedge i_clock) disable iff (i_reset)
		retire |-> tag != $past(tag));

endmodule

//--- source/cpu_core.sv
`timescale 1ns/1ps

module cpu_core #(
	parameter logic [31:0] stack_pointer = 32'h0000_0000
)(
	input i_clock,
	input i_reset,

	input                              i_valid,
	input  cpu_types_pkg::instruction_t i_instruction,

	output        o_retire,
	output [4:0]  o_retire_rd,
	output [31:0] o_result
);
	cpu_types_pkg::fetch_data_t  fetch_data;
	cpu_types_pkg::memory_data_t memory_data;
	logic [31:0] rs1;
	logic [31:0] rs2;

	cpu_decode decode (
		.i_clock       (i_clock),
		.i_reset       (i_reset),
		.i_valid       (i_valid),
		.i_instruction (i_instruction),
		.o_fetch_data  (fetch_data)
	);

	// operands come out one cycle after decode, together with execute's copy of fetch_data
	cpu_registers #(
		.stack_pointer (stack_pointer)
	) registers (
		.i_clock       (i_clock),
		.i_reset       (i_reset),
		.i_fetch_data  (fetch_data),
		.i_memory_data (memory_data),
		.o_rs1         (rs1),
		.o_rs2         (rs2)
	);

	cpu_execute execute (
		.i_clock       (i_clock),
		.i_reset       (i_reset),
		.i_fetch_data  (fetch_data),
		.i_rs1         (rs1),
		.i_rs2         (rs2),
		.o_memory_data (memory_data),	// loops back for write-back
		.o_retire      (o_retire),
		.o_retire_rd   (o_retire_rd),
		.o_result      (o_result)
	);

endmodule

//--- bench/cpu_core_tb.sv
`timescale 1ns/1ps

module cpu_core_tb;

	localparam logic [31:0] stack_pointer = 32'h0000_8000;
	localparam int retire_latency = 3;
	localparam logic [11:0] imm_funct3 = {3'b100, 3'b110, 3'b111, 3'b000};	// xori ori andi addi
	// slt srl sll xor or and sub add from the top
	// sub differs from add only in funct7
	localparam logic [23:0] reg_funct3 = {3'b010, 3'b101, 3'b001, 3'b100,
		3'b110, 3'b111, 3'b000, 3'b000};

	logic i_clock = 1'b0;
	logic i_reset = 1'b1;
	logic i_valid = 1'b0;
	cpu_types_pkg::instruction_t i_instruction = '0;
	logic        o_retire;
	logic [4:0]  o_retire_rd;
	logic [31:0] o_result;

	logic [31:0] ref_regs [32];	// what the register file should hold after each retire
	int seed = 32'h600d_0cf7;
	int errors = 0;
	int checks = 0;

	cpu_core #(
		.stack_pointer (stack_pointer)
	) uut (
		.i_clock       (i_clock),
		.i_reset       (i_reset),
		.i_valid       (i_valid),
		.i_instruction (i_instruction),
		.o_retire      (o_retire),
		.o_retire_rd   (o_retire_rd),
		.o_result      (o_result)
	);

	always #20 i_clock = ~i_clock;

	function automatic logic [31:0] r_instr(input logic [6:0] funct7, input logic [4:0] rs2,
			input logic [4:0] rs1, input logic [2:0] funct3, input logic [4:0] rd);
		return {funct7, rs2, rs1, funct3, rd, cpu_types_pkg::opcode_op};
	endfunction

	function automatic logic [31:0] i_instr(input logic [11:0] imm, input logic [4:0] rs1,
			input logic [2:0] funct3, input logic [4:0] rd);
		return {imm, rs1, funct3, rd, cpu_types_pkg::opcode_op_imm};
	endfunction

	// reference ALU working on the raw instruction bits and the bench's register copy
	function automatic logic [31:0] expected_result(input logic [31:0] instr);
		logic [31:0] a;
		logic [31:0] b;
		logic        is_op;
		is_op = (instr[6:0] == cpu_types_pkg::opcode_op);
		a = ref_regs[instr[19:15]];
		b = is_op ? ref_regs[instr[24:20]] : {{20{instr[31]}}, instr[31:20]};
		case (instr[14:12])
			3'b000:  return (is_op && instr[30]) ? a - b : a + b;
			3'b111:  return a & b;
			3'b110:  return a | b;
			3'b100:  return a ^ b;
			3'b001:  return a << b[4:0];
			3'b101:  return a >> b[4:0];
			3'b010:  return ($signed(a) < $signed(b)) ? 32'h1 : 32'h0;
			default: return 32'h0;
		endcase
	endfunction

	task automatic check_value(input string name, input logic [31:0] got,
			input logic [31:0] expected);
		checks++;
		assert (got === expected) else begin
			errors++;
			$display("mismatch %s: got %h expected %h", name, got, expected);
		end
	endtask

	task automatic issue(input logic [31:0] instr);
		@(posedge i_clock);
		i_valid <= 1'b1;
		i_instruction <= instr;
	endtask

	task automatic go_idle();
		@(posedge i_clock);
		i_valid <= 1'b0;
	endtask

	// counts falling edges from the end of issue until o_retire shows up
	task automatic wait_retire(input int limit, output bit seen, output int cycles);
		seen = 1'b0;
		cycles = 0;
		while (!seen && cycles < limit) begin
			@(negedge i_clock);
			cycles++;
			seen = (o_retire === 1'b1);
		end
	endtask

	task automatic run_instruction(input logic [31:0] instr);
		logic [31:0] expected;
		bit seen;
		int cycles;
		expected = expected_result(instr);
		issue(instr);
		go_idle();
		wait_retire(retire_latency + 4, seen, cycles);
		checks++;
		assert (seen) else begin
			errors++;
			$display("instruction %h never retired before the timeout", instr);
		end
		if (seen) begin
			check_value("retire latency", cycles, retire_latency);
			check_value("o_retire_rd", o_retire_rd, instr[11:7]);
			check_value("o_result", o_result, expected);
		end
		if (instr[11:7] != 5'd0)
			ref_regs[instr[11:7]] = expected;
	endtask

	task automatic test_reset_state();
		for (int r = 1; r < 32; r++)
			if (r != 2)
				run_instruction(i_instr(12'h000, r[4:0], 3'b000, r[4:0]));
		run_instruction(i_instr(12'h000, 5'd2, 3'b000, 5'd5));
		check_value("o_result", o_result, 32'h0000_8000);	// x2 came out of reset as sp
	endtask

	task automatic test_immediate_group();
		logic [31:0] rnd;
		run_instruction(i_instr(12'h800, 5'd2, 3'b000, 5'd6));
		for (int n = 0; n < 24; n++) begin
			rnd = $random(seed);
			run_instruction(i_instr(rnd[11:0], rnd[16:12], imm_funct3[3 * (n % 4) +: 3],
				rnd[21:17]));
		end
	endtask

	task automatic test_register_group();
		logic [31:0] rnd;
		for (int round = 0; round < 3; round++) begin
			rnd = $random(seed);
			run_instruction(i_instr(rnd[11:0], 5'd0, 3'b000, 5'd10));
			run_instruction(r_instr(7'h00, 5'd10, 5'd10, 3'b001, 5'd10));	// spread the bits
			run_instruction(i_instr(rnd[23:12], 5'd10, 3'b100, 5'd10));
			run_instruction(i_instr(rnd[31:20], 5'd0, 3'b000, 5'd11));
			for (int k = 0; k < 8; k++)
				run_instruction(r_instr((k == 1) ? 7'h20 : 7'h00, 5'd11, 5'd10,
					reg_funct3[3 * k +: 3], 5'd12));
		end
		run_instruction(i_instr(12'd45, 5'd0, 3'b000, 5'd11));	// shifts by 13 once masked
		run_instruction(r_instr(7'h00, 5'd11, 5'd10, 3'b001, 5'd13));
		run_instruction(r_instr(7'h00, 5'd11, 5'd10, 3'b101, 5'd14));
		run_instruction(i_instr(12'hfff, 5'd0, 3'b000, 5'd15));
		run_instruction(i_instr(12'h001, 5'd0, 3'b000, 5'd16));
		run_instruction(r_instr(7'h00, 5'd16, 5'd15, 3'b010, 5'd17));	// -1 < 1 only when signed
	endtask

	task automatic test_register_zero();
		run_instruction(i_instr(12'd123, 5'd7, 3'b000, 5'd0));
		run_instruction(r_instr(7'h00, 5'd0, 5'd0, 3'b110, 5'd8));
		check_value("o_result", o_result, 32'h0);
	endtask

	task automatic test_illegal_opcode();
		bit seen;
		int cycles;
		issue({12'h123, 5'd10, 3'b000, 5'd9, 7'b1111011});
		go_idle();
		wait_retire(retire_latency + 2, seen, cycles);
		checks++;
		assert (!seen) else begin
			errors++;
			$display("an instruction with an unknown opcode retired");
		end
		// reading every register into x0 leaves the file as it is
		for (int r = 1; r < 32; r++)
			run_instruction(i_instr(12'h000, r[4:0], 3'b000, 5'd0));
	endtask

	task automatic test_pipelining();
		logic [31:0] instrs [3];
		logic [31:0] expected [3];
		instrs[0] = i_instr(12'h5a5, 5'd0, 3'b000, 5'd20);
		instrs[1] = i_instr(12'h0f0, 5'd10, 3'b100, 5'd21);
		instrs[2] = r_instr(7'h20, 5'd11, 5'd12, 3'b000, 5'd22);
		for (int k = 0; k < 3; k++)
			expected[k] = expected_result(instrs[k]);
		for (int k = 0; k < 3; k++)
			issue(instrs[k]);
		go_idle();
		for (int k = 0; k < 3; k++) begin
			@(negedge i_clock);
			check_value("o_retire", o_retire, 1'b1);
			check_value("o_retire_rd", o_retire_rd, instrs[k][11:7]);
			check_value("o_result", o_result, expected[k]);
			ref_regs[instrs[k][11:7]] = expected[k];
		end
		@(negedge i_clock);
		check_value("o_retire", o_retire, 1'b0);
	endtask

	initial begin
		for (int r = 0; r < 32; r++)
			ref_regs[r] = (r == 2) ? stack_pointer : 32'h0;
		repeat (2) @(posedge i_clock);
		i_reset <= 1'b0;

		test_reset_state();
		test_immediate_group();
		test_register_group();
		test_register_zero();
		test_illegal_opcode();
		test_pipelining();

		@(posedge i_clock);
		$display("checks: %0d, errors: %0d", checks, errors);
		if (errors == 0)
			$display("All tests passed");
		else
			$display("Some tests failed");
		$finish;
	end

endmodule

//--- sources.f
source/cpu_types_pkg.sv
source/cpu_decode.sv
source/cpu_registers.sv
source/cpu_execute.sv
source/cpu_core.sv
bench/cpu_core_tb.sv
